// ==== hdl/rv32i_pkg.sv ====
package rv32i_pkg;

    typedef logic [31:0] word_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, five ways of reading it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_imm;
        logic    load_regfile;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    is_lui;
    } ctrl_word_t;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic       valid;
        ctrl_word_t ctrl;
        word_t      pc;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        ctrl_word_t ctrl;
        word_t      pc;
        logic [4:0] rd;
        logic [4:0] rs2;
        word_t      alu_result;
        word_t      store_data;
        logic       br_taken;
    } ex_mem_t;

    typedef struct packed {
        logic       valid;
        ctrl_word_t ctrl;
        logic [4:0] rd;
        word_t      alu_result;
        word_t      load_data;
    } mem_wb_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

endpackage

// ==== hdl/fetch_stage.sv ====
module fetch_stage #(
    parameter rv32i_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             stall_i,
    input  logic             redirect_i,
    input  rv32i_pkg::word_t target_i,
    output rv32i_pkg::word_t pc_o
);
    import rv32i_pkg::*;

    word_t pc_q;

    // a taken branch wins over a load-use hold
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

    // branch targets come from execute, so alignment depends on the immediate path
    pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00);

endmodule

// ==== hdl/decode_stage.sv ====
module decode_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  rv32i_pkg::if_id_t if_id_i,
    input  logic              wb_en_i,
    input  logic [4:0]        wb_rd_i,
    input  rv32i_pkg::word_t  wb_data_i,
    output rv32i_pkg::id_ex_t id_ex_o,
    output logic [4:0]        rs1_o,
    output logic [4:0]        rs2_o
);
    import rv32i_pkg::*;

    instr_u     instr;
    ctrl_word_t ctrl;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;
    word_t      u_imm;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      regs [1:31];

    function automatic alu_op_t alu_from_funct3(input logic [2:0] funct3, input logic sub);
        alu_op_t op;
        case (funct3)
            3'b000:  op = sub ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b100:  op = alu_xor;
            3'b101:  op = alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign instr = if_id_i.instr;

    assign i_imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign s_imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign b_imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
    assign u_imm = {instr.u_fmt.imm, 12'h000};

    always_comb begin
        ctrl = '0;
        imm  = i_imm;
        case (instr.r_fmt.opcode)
            opc_op: begin
                ctrl.alu_op       = alu_from_funct3(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
                ctrl.load_regfile = 1'b1;
            end
            opc_op_imm: begin
                ctrl.alu_op       = alu_from_funct3(instr.i_fmt.funct3, 1'b0);
                ctrl.alu_src_imm  = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            opc_lui: begin
                ctrl.is_lui       = 1'b1;
                ctrl.alu_src_imm  = 1'b1;
                ctrl.load_regfile = 1'b1;
                imm               = u_imm;
            end
            opc_load: begin
                ctrl.mem_read     = 1'b1;
                ctrl.alu_src_imm  = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            opc_store: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = s_imm;
            end
            opc_branch: begin
                // only beq and bne
                ctrl.branch    = (instr.b_fmt.funct3[2:1] == 2'b00);
                ctrl.branch_ne = instr.b_fmt.funct3[0];
                imm            = b_imm;
            end
            default: begin
                // unknown opcode stays a no-op
                ctrl = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_en_i && wb_rd_i != 5'd0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // write-through covers the writeback in the same cycle
    assign rs1_data = (instr.r_fmt.rs1 == 5'd0) ? '0 :
                      (wb_en_i && wb_rd_i == instr.r_fmt.rs1) ? wb_data_i : regs[instr.r_fmt.rs1];
    assign rs2_data = (instr.r_fmt.rs2 == 5'd0) ? '0 :
                      (wb_en_i && wb_rd_i == instr.r_fmt.rs2) ? wb_data_i : regs[instr.r_fmt.rs2];

    always_comb begin
        id_ex_o.valid    = if_id_i.valid;
        id_ex_o.ctrl     = ctrl;
        id_ex_o.pc       = if_id_i.pc;
        id_ex_o.rs1      = instr.r_fmt.rs1;
        id_ex_o.rs2      = instr.r_fmt.rs2;
        id_ex_o.rd       = instr.r_fmt.rd;
        id_ex_o.rs1_data = rs1_data;
        id_ex_o.rs2_data = rs2_data;
        id_ex_o.imm      = imm;
    end

    assign rs1_o = instr.r_fmt.rs1;
    assign rs2_o = instr.r_fmt.rs2;

    // writeback enable is built in the top level
    x0_never_written: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_en_i |-> wb_rd_i != 5'd0);

endmodule

// ==== hdl/execute_stage.sv ====
module execute_stage (
    input  rv32i_pkg::id_ex_t   id_ex_i,
    input  rv32i_pkg::fwd_sel_t forward_a_i,
    input  rv32i_pkg::fwd_sel_t forward_b_i,
    input  rv32i_pkg::word_t    mem_fwd_data_i,
    input  rv32i_pkg::word_t    wb_fwd_data_i,
    output rv32i_pkg::ex_mem_t  ex_mem_o
);
    import rv32i_pkg::*;

    word_t rs1_val;
    word_t rs2_val;
    word_t alu_a;
    word_t alu_b;
    word_t alu_y;

    function automatic word_t fwd_pick(input fwd_sel_t sel, input word_t reg_val,
                                       input word_t mem_val, input word_t wb_val);
        word_t val;
        case (sel)
            fwd_mem: val = mem_val;
            fwd_wb:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign rs1_val = fwd_pick(forward_a_i, id_ex_i.rs1_data, mem_fwd_data_i, wb_fwd_data_i);
    assign rs2_val = fwd_pick(forward_b_i, id_ex_i.rs2_data, mem_fwd_data_i, wb_fwd_data_i);

    // lui is 0 + upper immediate
    assign alu_a = id_ex_i.ctrl.is_lui ? '0 : rs1_val;
    assign alu_b = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            alu_add: alu_y = alu_a + alu_b;
            alu_sub: alu_y = alu_a - alu_b;
            alu_and: alu_y = alu_a & alu_b;
            alu_or:  alu_y = alu_a | alu_b;
            alu_xor: alu_y = alu_a ^ alu_b;
            alu_slt: alu_y = {31'd0, $signed(alu_a) < $signed(alu_b)};
            alu_sll: alu_y = alu_a << alu_b[4:0];
            default: alu_y = alu_a >> alu_b[4:0];
        endcase
    end

    always_comb begin
        ex_mem_o.valid      = id_ex_i.valid;
        ex_mem_o.ctrl       = id_ex_i.ctrl;
        ex_mem_o.pc         = id_ex_i.pc;
        ex_mem_o.rd         = id_ex_i.rd;
        ex_mem_o.rs2        = id_ex_i.rs2;
        // branches carry their target in the result field
        ex_mem_o.alu_result = id_ex_i.ctrl.branch ? id_ex_i.pc + id_ex_i.imm : alu_y;
        ex_mem_o.store_data = rs2_val;
        ex_mem_o.br_taken   = id_ex_i.ctrl.branch
                              && ((rs1_val == rs2_val) ^ id_ex_i.ctrl.branch_ne);
    end

endmodule

// ==== hdl/memory_stage.sv ====
module memory_stage (
    input  rv32i_pkg::ex_mem_t  ex_mem_i,
    input  rv32i_pkg::fwd_sel_t forward_c_i,
    input  rv32i_pkg::word_t    wb_fwd_data_i,
    input  rv32i_pkg::word_t    data_mem_rdata_i,
    output rv32i_pkg::word_t    data_mem_address_o,
    output rv32i_pkg::word_t    data_mem_wdata_o,
    output logic                data_read_o,
    output logic                data_write_o,
    output logic                redirect_o,
    output rv32i_pkg::word_t    target_o,
    output rv32i_pkg::mem_wb_t  mem_wb_o
);
    import rv32i_pkg::*;

    assign data_mem_address_o = ex_mem_i.alu_result;
    // a load right before the store supplies the data late
    assign data_mem_wdata_o   = (forward_c_i == fwd_wb) ? wb_fwd_data_i : ex_mem_i.store_data;
    assign data_read_o        = ex_mem_i.valid && ex_mem_i.ctrl.mem_read;
    assign data_write_o       = ex_mem_i.valid && ex_mem_i.ctrl.mem_write;

    assign redirect_o = ex_mem_i.valid && ex_mem_i.br_taken;
    assign target_o   = ex_mem_i.alu_result;

    always_comb begin
        mem_wb_o.valid      = ex_mem_i.valid;
        mem_wb_o.ctrl       = ex_mem_i.ctrl;
        mem_wb_o.rd         = ex_mem_i.rd;
        mem_wb_o.alu_result = ex_mem_i.alu_result;
        mem_wb_o.load_data  = data_mem_rdata_i;
    end

    // decode never sets both strobes for one opcode
    always_comb begin
        rd_wr_exclusive: assert #0 (!(data_read_o && data_write_o));
    end

endmodule

// ==== hdl/hazard_unit.sv ====
module hazard_unit (
    input  rv32i_pkg::id_ex_t   id_ex_i,
    input  rv32i_pkg::ex_mem_t  ex_mem_i,
    input  rv32i_pkg::mem_wb_t  mem_wb_i,
    input  logic [4:0]          id_rs1_i,
    input  logic [4:0]          id_rs2_i,
    input  logic                id_uses_rs2_in_ex_i,
    output rv32i_pkg::fwd_sel_t forward_a_o,
    output rv32i_pkg::fwd_sel_t forward_b_o,
    output rv32i_pkg::fwd_sel_t forward_c_o,
    output logic                stall_o
);
    import rv32i_pkg::*;

    logic mem_writes_alu;
    logic wb_writes;
    logic load_in_ex;
    logic load_in_mem;
    logic ex_uses_rs1;
    logic ex_uses_rs2;

    // loads in EX/MEM have no data yet
    assign mem_writes_alu = ex_mem_i.valid && ex_mem_i.ctrl.load_regfile
                            && !ex_mem_i.ctrl.mem_read && ex_mem_i.rd != 5'd0;
    assign wb_writes      = mem_wb_i.valid && mem_wb_i.ctrl.load_regfile && mem_wb_i.rd != 5'd0;

    function automatic fwd_sel_t ex_fwd(input logic [4:0] src, input logic mem_hit,
                                        input logic [4:0] mem_rd, input logic wb_hit,
                                        input logic [4:0] wb_rd);
        fwd_sel_t sel;
        sel = fwd_none;
        if (mem_hit && src == mem_rd) begin
            sel = fwd_mem;
        end else if (wb_hit && src == wb_rd) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    assign forward_a_o = ex_fwd(id_ex_i.rs1, mem_writes_alu, ex_mem_i.rd,
                                wb_writes, mem_wb_i.rd);
    assign forward_b_o = ex_fwd(id_ex_i.rs2, mem_writes_alu, ex_mem_i.rd,
                                wb_writes, mem_wb_i.rd);
    assign forward_c_o = (wb_writes && mem_wb_i.rd == ex_mem_i.rs2) ? fwd_wb : fwd_none;

    // hold ID one cycle behind a load it depends on
    assign load_in_ex = id_ex_i.valid && id_ex_i.ctrl.mem_read && id_ex_i.rd != 5'd0;
    assign stall_o    = load_in_ex
                        && (id_rs1_i == id_ex_i.rd
                            || (id_uses_rs2_in_ex_i && id_rs2_i == id_ex_i.rd));

    assign load_in_mem = ex_mem_i.valid && ex_mem_i.ctrl.mem_read && ex_mem_i.rd != 5'd0;
    assign ex_uses_rs1 = id_ex_i.valid && !id_ex_i.ctrl.is_lui
                         && (id_ex_i.ctrl.load_regfile || id_ex_i.ctrl.mem_write
                             || id_ex_i.ctrl.branch);
    assign ex_uses_rs2 = id_ex_i.valid
                         && (id_ex_i.ctrl.branch
                             || (id_ex_i.ctrl.load_regfile && !id_ex_i.ctrl.alu_src_imm));

    // the stall one cycle earlier keeps a load in EX/MEM from feeding execute
    always_comb begin
        no_load_fwd_in_ex: assert #0 (!(load_in_mem
            && ((ex_uses_rs1 && ex_mem_i.rd == id_ex_i.rs1)
                || (ex_uses_rs2 && ex_mem_i.rd == id_ex_i.rs2))));
    end

endmodule

// ==== hdl/datapath.sv ====
module datapath #(
    parameter rv32i_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst_n_i,

    output rv32i_pkg::word_t instr_mem_address_o,
    input  rv32i_pkg::word_t instr_mem_rdata_i,

    output rv32i_pkg::word_t data_mem_address_o,
    output rv32i_pkg::word_t data_mem_wdata_o,
    output logic             data_read_o,
    output logic             data_write_o,
    input  rv32i_pkg::word_t data_mem_rdata_i,

    output logic             commit_valid_o,
    output logic [4:0]       commit_rd_o,
    output rv32i_pkg::word_t commit_data_o
);
    import rv32i_pkg::*;

    word_t      pc;
    word_t      target;
    logic       redirect;
    logic       stall;

    if_id_t     if_id_q;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;
    ex_mem_t    ex_mem_d;
    ex_mem_t    ex_mem_q;
    mem_wb_t    mem_wb_d;
    mem_wb_t    mem_wb_q;

    logic [4:0] id_rs1;
    logic [4:0] id_rs2;
    logic       id_uses_rs2_in_ex;
    fwd_sel_t   forward_a;
    fwd_sel_t   forward_b;
    fwd_sel_t   forward_c;

    logic       wb_en;
    word_t      wb_data;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall),
        .redirect_i (redirect),
        .target_i   (target),
        .pc_o       (pc)
    );

    assign instr_mem_address_o = pc;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_id_q <= '0;
        end else if (redirect) begin
            if_id_q <= '0;
        end else if (!stall) begin
            if_id_q <= '{valid: 1'b1, pc: pc, instr: instr_u'(instr_mem_rdata_i)};
        end
    end

    decode_stage u_decode (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .if_id_i   (if_id_q),
        .wb_en_i   (wb_en),
        .wb_rd_i   (mem_wb_q.rd),
        .wb_data_i (wb_data),
        .id_ex_o   (id_ex_d),
        .rs1_o     (id_rs1),
        .rs2_o     (id_rs2)
    );

    // register-register ops and branches compare rs2 in execute
    assign id_uses_rs2_in_ex = id_ex_d.ctrl.branch
                               || (id_ex_d.ctrl.load_regfile && !id_ex_d.ctrl.alu_src_imm);

    // bubble on a load-use stall
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else if (redirect || stall) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    execute_stage u_execute (
        .id_ex_i        (id_ex_q),
        .forward_a_i    (forward_a),
        .forward_b_i    (forward_b),
        .mem_fwd_data_i (ex_mem_q.alu_result),
        .wb_fwd_data_i  (wb_data),
        .ex_mem_o       (ex_mem_d)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_q <= '0;
        end else if (redirect) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= ex_mem_d;
        end
    end

    memory_stage u_memory (
        .ex_mem_i           (ex_mem_q),
        .forward_c_i        (forward_c),
        .wb_fwd_data_i      (wb_data),
        .data_mem_rdata_i   (data_mem_rdata_i),
        .data_mem_address_o (data_mem_address_o),
        .data_mem_wdata_o   (data_mem_wdata_o),
        .data_read_o        (data_read_o),
        .data_write_o       (data_write_o),
        .redirect_o         (redirect),
        .target_o           (target),
        .mem_wb_o           (mem_wb_d)
    );

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q <= mem_wb_d;
        end
    end

    hazard_unit u_hazard (
        .id_ex_i             (id_ex_q),
        .ex_mem_i            (ex_mem_q),
        .mem_wb_i            (mem_wb_q),
        .id_rs1_i            (id_rs1),
        .id_rs2_i            (id_rs2),
        .id_uses_rs2_in_ex_i (id_uses_rs2_in_ex),
        .forward_a_o         (forward_a),
        .forward_b_o         (forward_b),
        .forward_c_o         (forward_c),
        .stall_o             (stall)
    );

    // writeback
    assign wb_data = mem_wb_q.ctrl.mem_read ? mem_wb_q.load_data : mem_wb_q.alu_result;
    assign wb_en   = mem_wb_q.valid && mem_wb_q.ctrl.load_regfile && mem_wb_q.rd != 5'd0;

    assign commit_valid_o = wb_en;
    assign commit_rd_o    = mem_wb_q.rd;
    assign commit_data_o  = wb_data;

endmodule

// ==== verif/tb_datapath.sv ====
module tb_datapath;
    import rv32i_pkg::*;

    localparam int PROG_LEN  = 200;
    localparam int TIMEOUT   = PROG_LEN * 4 + 100;
    localparam int IDLE_TAIL = 10;

    typedef enum logic [4:0] {
        k_add, k_sub, k_and, k_or, k_xor, k_slt, k_sll, k_srl,
        k_addi, k_andi, k_ori, k_xori, k_slti, k_lui, k_lw, k_sw, k_beq, k_bne
    } kind_t;

    typedef struct packed {
        kind_t      kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        word_t      imm;
    } instr_rec_t;

    typedef struct packed {
        kind_t      kind;
        logic [4:0] rd;
        word_t      data;
    } commit_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic       clk;
    logic       rst_n_i;
    word_t      instr_mem_address_o;
    word_t      instr_mem_rdata_i;
    word_t      data_mem_address_o;
    word_t      data_mem_wdata_o;
    logic       data_read_o;
    logic       data_write_o;
    word_t      data_mem_rdata_i;
    logic       commit_valid_o;
    logic [4:0] commit_rd_o;
    word_t      commit_data_o;

    instr_rec_t prog [0:PROG_LEN-1];
    word_t      imem [0:255];
    word_t      dmem [0:63];
    word_t      ref_mem [0:63];
    commit_t    exp_commits [$];
    store_t     exp_stores [$];
    word_t      exp_loads [$];
    int         commit_idx;
    int         store_idx;
    int         load_idx;
    int         err_commit;
    int         err_store;
    int         err_load;
    int         err_other;
    int         cycles;
    int         idle;

    datapath #(
        .RESET_PC(32'h0000_0000)
    ) dut (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .instr_mem_address_o (instr_mem_address_o),
        .instr_mem_rdata_i   (instr_mem_rdata_i),
        .data_mem_address_o  (data_mem_address_o),
        .data_mem_wdata_o    (data_mem_wdata_o),
        .data_read_o         (data_read_o),
        .data_write_o        (data_write_o),
        .data_mem_rdata_i    (data_mem_rdata_i),
        .commit_valid_o      (commit_valid_o),
        .commit_rd_o         (commit_rd_o),
        .commit_data_o       (commit_data_o)
    );

    always #20 clk = ~clk;

    // both memories answer in the same cycle
    assign instr_mem_rdata_i = imem[instr_mem_address_o[9:2]];
    assign data_mem_rdata_i  = dmem[data_mem_address_o[7:2]];

    always @(posedge clk) begin
        if (data_write_o) begin
            dmem[data_mem_address_o[7:2]] <= data_mem_wdata_o;
        end
    end

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // reuse the newest destination half the time for dense hazards
    function automatic logic [4:0] pick_src(input logic [4:0] last_rd);
        if ($urandom % 2 == 0) begin
            return last_rd;
        end
        return 5'($urandom % 8);
    endfunction

    function automatic word_t encode(input instr_rec_t r);
        logic [11:0] i12;
        logic [12:0] b13;
        i12 = r.imm[11:0];
        b13 = r.imm[12:0];
        case (r.kind)
            k_add:   return {7'h00, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
            k_sub:   return {7'h20, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
            k_and:   return {7'h00, r.rs2, r.rs1, 3'b111, r.rd, 7'b0110011};
            k_or:    return {7'h00, r.rs2, r.rs1, 3'b110, r.rd, 7'b0110011};
            k_xor:   return {7'h00, r.rs2, r.rs1, 3'b100, r.rd, 7'b0110011};
            k_slt:   return {7'h00, r.rs2, r.rs1, 3'b010, r.rd, 7'b0110011};
            k_sll:   return {7'h00, r.rs2, r.rs1, 3'b001, r.rd, 7'b0110011};
            k_srl:   return {7'h00, r.rs2, r.rs1, 3'b101, r.rd, 7'b0110011};
            k_addi:  return {i12, r.rs1, 3'b000, r.rd, 7'b0010011};
            k_andi:  return {i12, r.rs1, 3'b111, r.rd, 7'b0010011};
            k_ori:   return {i12, r.rs1, 3'b110, r.rd, 7'b0010011};
            k_xori:  return {i12, r.rs1, 3'b100, r.rd, 7'b0010011};
            k_slti:  return {i12, r.rs1, 3'b010, r.rd, 7'b0010011};
            k_lui:   return {r.imm[19:0], r.rd, 7'b0110111};
            k_lw:    return {i12, r.rs1, 3'b010, r.rd, 7'b0000011};
            k_sw:    return {i12[11:5], r.rs2, r.rs1, 3'b010, i12[4:0], 7'b0100011};
            k_beq:   return {b13[12], b13[10:5], r.rs2, r.rs1, 3'b000, b13[4:1], b13[11],
                             7'b1100011};
            k_bne:   return {b13[12], b13[10:5], r.rs2, r.rs1, 3'b001, b13[4:1], b13[11],
                             7'b1100011};
            default: return 32'h0;
        endcase
    endfunction

    task automatic gen_program();
        instr_rec_t r;
        logic [4:0] last_rd;
        last_rd = 5'd1;
        // prologue gives every register a known value
        for (int i = 0; i < 31; i++) begin
            r      = '0;
            r.kind = k_addi;
            r.rd   = 5'(i + 1);
            r.imm  = sext12(12'($urandom));
            prog[i] = r;
        end
        for (int i = 31; i < PROG_LEN - 1; i++) begin
            r      = '0;
            r.kind = kind_t'(5'($urandom % 18));
            // forward branches must land inside the program
            if ((r.kind == k_beq || r.kind == k_bne) && i + 8 >= PROG_LEN) begin
                r.kind = k_addi;
            end
            r.rd  = 5'($urandom % 8);
            r.rs1 = pick_src(last_rd);
            r.rs2 = pick_src(last_rd);
            case (r.kind)
                k_lui: r.imm = {12'h000, 20'($urandom)};
                k_lw, k_sw: begin
                    r.rs1 = 5'd0;
                    r.imm = ($urandom % 64) * 4;
                end
                k_beq, k_bne: begin
                    r.imm = (2 + $urandom % 7) * 4;
                    if ($urandom % 2 == 0) begin
                        r.rs2 = r.rs1;
                    end
                end
                default: r.imm = sext12(12'($urandom));
            endcase
            prog[i] = r;
            if (r.kind != k_sw && r.kind != k_beq && r.kind != k_bne) begin
                last_rd = r.rd;
            end
        end
        // beq x0, x0, 0 parks the core
        r      = '0;
        r.kind = k_beq;
        prog[PROG_LEN-1] = r;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < PROG_LEN) ? encode(prog[i]) : 32'h0;
        end
    endtask

    // architectural model stepping one instruction at a time
    task automatic run_model();
        word_t      x [0:31];
        instr_rec_t r;
        word_t      a;
        word_t      b;
        word_t      res;
        logic       wr;
        int         pc;
        int         nxt;
        commit_t    c;
        store_t     s;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = 0;
        while (pc != PROG_LEN - 1) begin
            r   = prog[pc];
            a   = x[r.rs1];
            b   = x[r.rs2];
            res = '0;
            wr  = 1'b1;
            nxt = pc + 1;
            case (r.kind)
                k_add:  res = a + b;
                k_sub:  res = a - b;
                k_and:  res = a & b;
                k_or:   res = a | b;
                k_xor:  res = a ^ b;
                k_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                k_sll:  res = a << b[4:0];
                k_srl:  res = a >> b[4:0];
                k_addi: res = a + r.imm;
                k_andi: res = a & r.imm;
                k_ori:  res = a | r.imm;
                k_xori: res = a ^ r.imm;
                k_slti: res = ($signed(a) < $signed(r.imm)) ? 32'd1 : 32'd0;
                k_lui:  res = {r.imm[19:0], 12'h000};
                k_lw: begin
                    res = ref_mem[r.imm[7:2]];
                    exp_loads.push_back(r.imm);
                end
                k_sw: begin
                    wr = 1'b0;
                    ref_mem[r.imm[7:2]] = b;
                    s.addr = r.imm;
                    s.data = b;
                    exp_stores.push_back(s);
                end
                default: begin
                    wr = 1'b0;
                    if ((a == b) != (r.kind == k_bne)) begin
                        nxt = pc + int'(r.imm[7:2]);
                    end
                end
            endcase
            if (wr && r.rd != 5'd0) begin
                x[r.rd] = res;
                c.kind  = r.kind;
                c.rd    = r.rd;
                c.data  = res;
                exp_commits.push_back(c);
            end
            pc = nxt;
        end
    endtask

    task automatic check_reset_quiet();
        assert (!commit_valid_o && !data_read_o && !data_write_o) else begin
            err_other++;
            $display("commit or memory strobe high while reset is asserted");
        end
    endtask

    task automatic check_commit();
        commit_t e;
        if (commit_valid_o) begin
            assert (commit_idx < exp_commits.size()) else begin
                err_other++;
                $display("unexpected commit to x%0d after all expected commits", commit_rd_o);
            end
            if (commit_idx < exp_commits.size()) begin
                e = exp_commits[commit_idx];
                assert (commit_rd_o == e.rd && commit_data_o == e.data) else begin
                    err_commit++;
                    $display("** Error commit %0d (%s): expected x%0d=%h, actual x%0d=%h",
                             commit_idx, e.kind.name(), e.rd, e.data, commit_rd_o,
                             commit_data_o);
                end
                commit_idx++;
            end
        end
    endtask

    task automatic check_store();
        store_t e;
        if (data_write_o) begin
            assert (store_idx < exp_stores.size()) else begin
                err_other++;
                $display("unexpected store to %h after all expected stores", data_mem_address_o);
            end
            if (store_idx < exp_stores.size()) begin
                e = exp_stores[store_idx];
                assert (data_mem_address_o == e.addr && data_mem_wdata_o == e.data) else begin
                    err_store++;
                    $display("** Error store %0d: expected [%h]=%h, actual [%h]=%h",
                             store_idx, e.addr, e.data, data_mem_address_o, data_mem_wdata_o);
                end
                store_idx++;
            end
        end
    endtask

    task automatic check_load();
        word_t e;
        if (data_read_o) begin
            assert (load_idx < exp_loads.size()) else begin
                err_other++;
                $display("unexpected load from %h after all expected loads", data_mem_address_o);
            end
            if (load_idx < exp_loads.size()) begin
                e = exp_loads[load_idx];
                assert (data_mem_address_o == e) else begin
                    err_load++;
                    $display("** Error load %0d: expected address %h, actual %h",
                             load_idx, e, data_mem_address_o);
                end
                load_idx++;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n_i    = 1'b0;
        commit_idx = 0;
        store_idx  = 0;
        load_idx   = 0;
        err_commit = 0;
        err_store  = 0;
        err_load   = 0;
        err_other  = 0;
        cycles     = 0;
        idle       = 0;
        void'($urandom(61));
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = $urandom;
            dmem[i]   <= ref_mem[i];
        end
        gen_program();
        run_model();

        repeat (10) begin
            @(negedge clk);
            check_reset_quiet();
        end
        assert (instr_mem_address_o == 32'h0000_0000) else begin
            err_other++;
            $display("** Error first_fetch: expected %h, actual %h", 32'h0, instr_mem_address_o);
        end
        rst_n_i = 1'b1;

        while (idle < IDLE_TAIL && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            check_commit();
            check_store();
            check_load();
            if (commit_idx == exp_commits.size() && store_idx == exp_stores.size()
                && load_idx == exp_loads.size()) begin
                idle++;
            end
        end
        if (idle < IDLE_TAIL) begin
            err_other++;
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        end

        $display("errors: commit %0d, store %0d, load %0d, other %0d",
                 err_commit, err_store, err_load, err_other);
        if (err_commit + err_store + err_load + err_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/rv32i_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/datapath.sv
verif/tb_datapath.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_datapath \
    -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_datapath > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0
